//--- include/fb_defs.svh
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// framebuffer geometry in pixels
`define FB_WIDTH  160
`define FB_HEIGHT 120

// external async SRAM pin widths
`define SRAM_ADDR_W 21
`define SRAM_DATA_W 16

// one chip per buffer
// chip 0 is the left part (buffer A) and chip 1 is the right part (buffer B)
`define NUM_FB 2

`endif

//--- rtl/fb_pkg.sv
`include "fb_defs.svh"

package fb_pkg;

    // ------------------------------------------------------------------------
    // pixel word
    // ------------------------------------------------------------------------

    // rgb565 field layout, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one 16-bit word with two views
    // the sram side moves raw words and the display side reads the fields
    typedef union packed {
        logic [`SRAM_DATA_W-1:0] raw;
        rgb565_t                 rgb;
    } color16_t;

    // ------------------------------------------------------------------------
    // buffer naming
    // ------------------------------------------------------------------------

    // encoding equals the chip index in the generate loop
    typedef enum logic {
        FB_A = 1'b0,
        FB_B = 1'b1
    } fb_sel_t;

endpackage

//--- rtl/sram_bus_if.sv
`timescale 1ns/1ps
`include "fb_defs.svh"

// one async SRAM chip as seen from inside the design
interface sram_bus_if;

    // address and active-low controls
    logic [`SRAM_ADDR_W-1:0] addr;
    logic                    cs_n;
    logic                    we_n;
    logic                    oe_n;

    // outgoing write data and its pad enable
    logic [`SRAM_DATA_W-1:0] dq_out;
    logic                    dq_oe;

    // value seen on the dq pins
    logic [`SRAM_DATA_W-1:0] dq_in;

    // chip port drives the pins and may look at the returned data
    modport port (
        output addr, cs_n, we_n, oe_n,
        output dq_out, dq_oe,
        input  dq_in
    );

    // read selector only samples the returned data
    modport sel (
        input dq_in
    );

endinterface

//--- rtl/fb_request_router.sv
`timescale 1ns/1ps
`include "fb_defs.svh"

module fb_request_router (
    input  logic                            clk_write,
    input  logic                            clk_read,
    input  logic                            rst,
    input  logic                            swap,
    input  logic                            write_enable,
    input  logic [$clog2(`FB_WIDTH)-1:0]    write_x,
    input  logic [$clog2(`FB_HEIGHT)-1:0]   write_y,
    input  fb_pkg::color16_t                write_data,
    input  logic [$clog2(`FB_WIDTH)-1:0]    read_x,
    input  logic [$clog2(`FB_HEIGHT)-1:0]   read_y,
    output logic [`NUM_FB-1:0]              wr_req,
    output logic [`SRAM_ADDR_W-1:0]         wr_addr,
    output fb_pkg::color16_t                wr_data,
    output logic [`NUM_FB-1:0]              rd_req,
    output logic [`SRAM_ADDR_W-1:0]         rd_addr,
    output logic [`NUM_FB-1:0]              is_back,
    output fb_pkg::fb_sel_t                 front_sel
);
    import fb_pkg::*;

    // linear pixel index width
    localparam int FB_DEPTH = `FB_WIDTH * `FB_HEIGHT;
    localparam int LIN_W    = $clog2(FB_DEPTH);

    fb_sel_t          write_sel;
    fb_sel_t          write_sel_next;
    logic             front_toggle;
    logic             sync_ff1;
    logic             sync_ff2;
    logic [LIN_W-1:0] wr_lin;
    logic [LIN_W-1:0] rd_lin;

    // ------------------------------------------------------------------------
    // address math
    // ------------------------------------------------------------------------

    // row-major, y * width + x
    assign wr_lin = LIN_W'(write_y * `FB_WIDTH + write_x);
    assign rd_lin = LIN_W'(read_y * `FB_WIDTH + read_x);

    // read address goes straight to the chip ports, they register it
    assign rd_addr = `SRAM_ADDR_W'(rd_lin);

    // ------------------------------------------------------------------------
    // write domain roles
    // ------------------------------------------------------------------------

    // role after this edge, a swap takes effect at the edge it is seen on
    assign write_sel_next = swap ? ((write_sel == FB_A) ? FB_B : FB_A) : write_sel;

    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            // render into B, scan out A
            write_sel    <= FB_B;
            front_toggle <= 1'b0;
        end else begin
            write_sel    <= write_sel_next;
            // flips once per swap, read side decodes the level
            front_toggle <= front_toggle ^ swap;
        end
    end

    // one-hot role flags per chip
    assign is_back = `NUM_FB'(1) << write_sel;

    // write request stage
    // steered by the post-swap role so it lines up with is_back
    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            wr_req <= '0;
        end else begin
            wr_req <= write_enable ? (`NUM_FB'(1) << write_sel_next) : '0;
        end
    end

    // payload follows the request, held otherwise
    always_ff @(posedge clk_write) begin
        if (write_enable) begin
            wr_addr <= `SRAM_ADDR_W'(wr_lin);
            wr_data <= write_data;
        end
    end

    // ------------------------------------------------------------------------
    // read domain front select
    // ------------------------------------------------------------------------

    // two-flop sync of the toggle level
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            sync_ff1 <= 1'b0;
            sync_ff2 <= 1'b0;
        end else begin
            sync_ff1 <= front_toggle;
            sync_ff2 <= sync_ff1;
        end
    end

    // decode register, third edge of the swap latency
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            front_sel <= FB_A;
        end else begin
            front_sel <= sync_ff2 ? FB_B : FB_A;
        end
    end

    // every cycle is a read of the front chip
    assign rd_req = `NUM_FB'(1) << front_sel;

    // never write two chips at once
    a_wr_onehot: assert property (@(posedge clk_write) disable iff (rst)
        $onehot0(wr_req));

endmodule

//--- rtl/sram_chip_port.sv
`timescale 1ns/1ps
`include "fb_defs.svh"

module sram_chip_port (
    input  logic                    clk_write,
    input  logic                    clk_read,
    input  logic                    rst,
    input  logic                    wr_req,
    input  logic [`SRAM_ADDR_W-1:0] wr_addr,
    input  fb_pkg::color16_t        wr_data,
    input  logic                    rd_req,
    input  logic [`SRAM_ADDR_W-1:0] rd_addr,
    input  logic                    is_back,
    sram_bus_if.port                bus
);
    import fb_pkg::*;

    // write set in the clk_write domain
    logic                    wr_cs_n;
    logic                    wr_we_n;
    logic                    wr_dq_oe;
    logic                    wr_role;
    logic [`SRAM_ADDR_W-1:0] wr_addr_q;
    color16_t                wr_data_q;

    // read set in the clk_read domain
    logic                    rd_cs_n;
    logic                    rd_oe_n;
    logic [`SRAM_ADDR_W-1:0] rd_addr_q;

    // ------------------------------------------------------------------------
    // write strobes
    // ------------------------------------------------------------------------

    // one clk_write cycle of cs/we/dq_oe per request
    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            wr_cs_n  <= 1'b1;
            wr_we_n  <= 1'b1;
            wr_dq_oe <= 1'b0;
            // idle read set on the pins while in reset
            wr_role  <= 1'b0;
        end else begin
            wr_cs_n  <= ~wr_req;
            wr_we_n  <= ~wr_req;
            wr_dq_oe <= wr_req;
            // role travels with the strobe so a swap right behind
            // a write cannot cut that write off the pins
            wr_role  <= is_back;
        end
    end

    // address and data held between writes
    always_ff @(posedge clk_write) begin
        if (wr_req) begin
            wr_addr_q <= wr_addr;
            wr_data_q <= wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // read strobes
    // ------------------------------------------------------------------------

    // front chip stays selected with oe low every cycle
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            rd_cs_n <= 1'b1;
            rd_oe_n <= 1'b1;
        end else begin
            rd_cs_n <= ~rd_req;
            rd_oe_n <= ~rd_req;
        end
    end

    // new address each cycle and data taken one edge later
    always_ff @(posedge clk_read) begin
        rd_addr_q <= rd_addr;
    end

    // ------------------------------------------------------------------------
    // pin mux
    // ------------------------------------------------------------------------

    // write data always presented and pads only open for a write
    assign bus.dq_out = wr_data_q.raw;

    always_comb begin
        if (wr_role) begin
            // back buffer is write only
            bus.addr  = wr_addr_q;
            bus.cs_n  = wr_cs_n;
            bus.we_n  = wr_we_n;
            bus.oe_n  = 1'b1;
            bus.dq_oe = wr_dq_oe;
        end else begin
            // front buffer is read only
            bus.addr  = rd_addr_q;
            bus.cs_n  = rd_cs_n;
            bus.we_n  = 1'b1;
            bus.oe_n  = rd_oe_n;
            bus.dq_oe = 1'b0;
        end
    end

    // router only requests writes for the chip that is back
    a_wr_on_back: assert property (@(posedge clk_write) disable iff (rst)
        wr_req |-> is_back);

    // pads driven only together with a write strobe
    a_oe_we: assert property (@(posedge clk_write) disable iff (rst)
        bus.dq_oe |-> !bus.we_n);

endmodule

//--- rtl/fb_read_select.sv
`timescale 1ns/1ps
`include "fb_defs.svh"

module fb_read_select (
    input  logic             clk_read,
    input  logic             rst,
    input  fb_pkg::fb_sel_t  front_sel,
    sram_bus_if.sel          bus [`NUM_FB],
    output fb_pkg::color16_t read_data
);
    import fb_pkg::*;

    // returned words, indexable by buffer
    logic [`SRAM_DATA_W-1:0] dq_chip [`NUM_FB];

    // buffer addressed on the previous edge
    fb_sel_t front_prev;

    // ------------------------------------------------------------------------
    // taps
    // ------------------------------------------------------------------------

    // interface arrays need a constant index
    for (genvar i = 0; i < `NUM_FB; i++) begin : g_tap
        assign dq_chip[i] = bus[i].dq_in;
    end

    // ------------------------------------------------------------------------
    // capture
    // ------------------------------------------------------------------------

    // the chip addressed at edge N holds its data at edge N+1
    // a swap in flight therefore still drains the old front for one cycle
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            front_prev <= FB_A;
            read_data  <= '0;
        end else begin
            front_prev     <= front_sel;
            read_data.raw  <= dq_chip[front_prev];
        end
    end

    // leaving reset the pixel output starts from a known word
    a_data_known: assert property (@(posedge clk_read)
        $fell(rst) |-> !$isunknown(read_data));

endmodule

//--- rtl/double_framebuffer.sv
`timescale 1ns/1ps
`include "fb_defs.svh"

module double_framebuffer (
    // clocks and reset
    input  logic                          clk_write,
    input  logic                          clk_read,
    input  logic                          rst,
    input  logic                          swap,

    // render side
    input  logic                          write_enable,
    input  logic [$clog2(`FB_WIDTH)-1:0]  write_x,
    input  logic [$clog2(`FB_HEIGHT)-1:0] write_y,
    input  fb_pkg::color16_t              write_data,

    // scan-out side
    input  logic [$clog2(`FB_WIDTH)-1:0]  read_x,
    input  logic [$clog2(`FB_HEIGHT)-1:0] read_y,
    output fb_pkg::color16_t              read_data,

    // left chip holds buffer A
    output logic [`SRAM_ADDR_W-1:0]       sram_l_addr,
    inout  wire  [`SRAM_DATA_W-1:0]       sram_l_dq,
    output logic                          sram_l_cs_n,
    output logic                          sram_l_we_n,
    output logic                          sram_l_oe_n,
    output logic                          sram_l_ub_n,
    output logic                          sram_l_lb_n,

    // right chip holds buffer B
    output logic [`SRAM_ADDR_W-1:0]       sram_r_addr,
    inout  wire  [`SRAM_DATA_W-1:0]       sram_r_dq,
    output logic                          sram_r_cs_n,
    output logic                          sram_r_we_n,
    output logic                          sram_r_oe_n,
    output logic                          sram_r_ub_n,
    output logic                          sram_r_lb_n
);
    import fb_pkg::*;

    // router to chip ports
    logic [`NUM_FB-1:0]      wr_req;
    logic [`SRAM_ADDR_W-1:0] wr_addr;
    color16_t                wr_data;
    logic [`NUM_FB-1:0]      rd_req;
    logic [`SRAM_ADDR_W-1:0] rd_addr;
    logic [`NUM_FB-1:0]      is_back;
    fb_sel_t                 front_sel;

    // one bundle per chip with index 0 on the left
    sram_bus_if bus [`NUM_FB] ();

    // ------------------------------------------------------------------------
    // request routing
    // ------------------------------------------------------------------------
    fb_request_router u_router (
        .clk_write    (clk_write),
        .clk_read     (clk_read),
        .rst          (rst),
        .swap         (swap),
        .write_enable (write_enable),
        .write_x      (write_x),
        .write_y      (write_y),
        .write_data   (write_data),
        .read_x       (read_x),
        .read_y       (read_y),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .is_back      (is_back),
        .front_sel    (front_sel)
    );

    // ------------------------------------------------------------------------
    // chip ports
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < `NUM_FB; g++) begin : g_chip
        sram_chip_port u_port (
            .clk_write (clk_write),
            .clk_read  (clk_read),
            .rst       (rst),
            .wr_req    (wr_req[g]),
            .wr_addr   (wr_addr),
            .wr_data   (wr_data),
            .rd_req    (rd_req[g]),
            .rd_addr   (rd_addr),
            .is_back   (is_back[g]),
            .bus       (bus[g])
        );
    end

    // pixel return path
    fb_read_select u_rsel (
        .clk_read  (clk_read),
        .rst       (rst),
        .front_sel (front_sel),
        .bus       (bus),
        .read_data (read_data)
    );

    // ------------------------------------------------------------------------
    // pins
    // ------------------------------------------------------------------------

    // left chip
    assign sram_l_addr  = bus[0].addr;
    assign sram_l_cs_n  = bus[0].cs_n;
    assign sram_l_we_n  = bus[0].we_n;
    assign sram_l_oe_n  = bus[0].oe_n;
    assign sram_l_dq    = bus[0].dq_oe ? bus[0].dq_out : 'z;
    assign bus[0].dq_in = sram_l_dq;

    // right chip
    assign sram_r_addr  = bus[1].addr;
    assign sram_r_cs_n  = bus[1].cs_n;
    assign sram_r_we_n  = bus[1].we_n;
    assign sram_r_oe_n  = bus[1].oe_n;
    assign sram_r_dq    = bus[1].dq_oe ? bus[1].dq_out : 'z;
    assign bus[1].dq_in = sram_r_dq;

    // whole 16-bit words only with both byte lanes always on
    assign sram_l_ub_n = 1'b0;
    assign sram_l_lb_n = 1'b0;
    assign sram_r_ub_n = 1'b0;
    assign sram_r_lb_n = 1'b0;

endmodule

//--- testbench/sram_model.sv
`timescale 1ns/1ps
`include "fb_defs.svh"

// behavioral async SRAM for whole 16-bit words without timing checks
module sram_model #(
    parameter logic [15:0] FILL_SALT = 16'h0000
) (
    input  logic [`SRAM_ADDR_W-1:0] addr,
    inout  wire  [`SRAM_DATA_W-1:0] dq,
    input  logic                    cs_n,
    input  logic                    we_n,
    input  logic                    oe_n,
    input  logic                    ub_n,
    input  logic                    lb_n
);

    // 32k words cover the 160x120 frame
    localparam int DEPTH = 1 << 15;

    logic [`SRAM_DATA_W-1:0] mem [DEPTH];
    logic [14:0]             lat_addr;
    logic [`SRAM_DATA_W-1:0] lat_data;
    logic                    lat_valid;
    logic                    word_en;

    // fill word depends on every address bit
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 16'(i) ^ FILL_SALT;
        end
        lat_valid = 1'b0;
    end

    // only whole words are moved so both byte lanes must be on
    assign word_en = !cs_n && !ub_n && !lb_n;

    // read drives the pins while selected with oe low and no write
    assign dq = (word_en && !oe_n && we_n) ? mem[addr[14:0]] : 'z;

    // follow the settled address and data while the write strobe is low
    always @(*) begin
        if (word_en && !we_n && !$isunknown(dq)) begin
            lat_addr  = addr[14:0];
            lat_data  = dq;
            lat_valid = 1'b1;
        end
    end

    // word is stored when the strobe ends
    always @(posedge we_n) begin
        if (lat_valid) begin
            mem[lat_addr] = lat_data;
            lat_valid     = 1'b0;
        end
    end

    // backdoor access
    function automatic logic [15:0] peek(input int a);
        return mem[a];
    endfunction

    task automatic preload(input int a, input logic [15:0] d);
        mem[a] = d;
    endtask

endmodule

//--- testbench/tb_double_framebuffer.sv
`timescale 1ns/1ps
`include "fb_defs.svh"

module tb_double_framebuffer;
    import fb_pkg::*;

    localparam int          FB_DEPTH   = `FB_WIDTH * `FB_HEIGHT;
    localparam int          NUM_ENTRY  = 30;
    localparam int          TIMEOUT    = 64;
    localparam logic [15:0] SEED       = 16'd19;
    localparam int          PROBE_X    = `FB_WIDTH - 1;
    localparam int          PROBE_Y    = `FB_HEIGHT - 1;
    localparam int          PROBE_ADDR = PROBE_Y * `FB_WIDTH + PROBE_X;
    localparam logic [1:0]  OP_WRITE   = 2'd0;
    localparam logic [1:0]  OP_READ    = 2'd1;
    localparam logic [1:0]  OP_SWAP    = 2'd2;
    localparam logic [1:0]  OP_WRSCAN  = 2'd3;

    // one table row
    // exp is the checked word and keep the untouched front word
    typedef struct packed {
        logic [2:0]  tst;
        logic [1:0]  op;
        logic [7:0]  x;
        logic [6:0]  y;
        logic [15:0] pix;
        logic [15:0] exp;
        logic [15:0] keep;
    } entry_t;

    logic clk_read;
    logic clk_write;
    logic rst;
    logic swap;
    logic write_enable;
    logic [$clog2(`FB_WIDTH)-1:0]  write_x;
    logic [$clog2(`FB_HEIGHT)-1:0] write_y;
    color16_t                      write_data;
    logic [$clog2(`FB_WIDTH)-1:0]  read_x;
    logic [$clog2(`FB_HEIGHT)-1:0] read_y;
    color16_t                      read_data;

    wire [`SRAM_ADDR_W-1:0] sram_l_addr;
    wire [`SRAM_ADDR_W-1:0] sram_r_addr;
    wire [`SRAM_DATA_W-1:0] sram_l_dq;
    wire [`SRAM_DATA_W-1:0] sram_r_dq;
    wire                    sram_l_cs_n;
    wire                    sram_l_we_n;
    wire                    sram_l_oe_n;
    wire                    sram_l_ub_n;
    wire                    sram_l_lb_n;
    wire                    sram_r_cs_n;
    wire                    sram_r_we_n;
    wire                    sram_r_oe_n;
    wire                    sram_r_ub_n;
    wire                    sram_r_lb_n;

    entry_t      tbl [NUM_ENTRY];
    logic [15:0] shadow [2][FB_DEPTH];
    logic [15:0] lfsr_state;
    string       names [1:6];
    int          test_err [1:6];
    int          cur_test;
    int          checks;
    int          back;
    int          n_built;

    // ------------------------------------------------------------------------
    // clocks, DUT and chip models
    // ------------------------------------------------------------------------
    initial begin
        clk_read = 1'b0;
        forever #20 clk_read = ~clk_read;
    end

    initial begin
        clk_write = 1'b0;
        forever #15 clk_write = ~clk_write;
    end

    double_framebuffer DUT (
        .clk_write (clk_write),       .clk_read (clk_read),
        .rst (rst),                   .swap (swap),
        .write_enable (write_enable), .write_x (write_x),
        .write_y (write_y),           .write_data (write_data),
        .read_x (read_x),             .read_y (read_y),
        .read_data (read_data),
        .sram_l_addr (sram_l_addr),   .sram_l_dq (sram_l_dq),
        .sram_l_cs_n (sram_l_cs_n),   .sram_l_we_n (sram_l_we_n),
        .sram_l_oe_n (sram_l_oe_n),   .sram_l_ub_n (sram_l_ub_n),
        .sram_l_lb_n (sram_l_lb_n),
        .sram_r_addr (sram_r_addr),   .sram_r_dq (sram_r_dq),
        .sram_r_cs_n (sram_r_cs_n),   .sram_r_we_n (sram_r_we_n),
        .sram_r_oe_n (sram_r_oe_n),   .sram_r_ub_n (sram_r_ub_n),
        .sram_r_lb_n (sram_r_lb_n)
    );

    // buffer A on the left and buffer B on the right
    sram_model #(.FILL_SALT(16'h5A00)) u_sram_l (
        .addr (sram_l_addr), .dq (sram_l_dq), .cs_n (sram_l_cs_n), .we_n (sram_l_we_n),
        .oe_n (sram_l_oe_n), .ub_n (sram_l_ub_n), .lb_n (sram_l_lb_n)
    );

    sram_model #(.FILL_SALT(16'hC300)) u_sram_r (
        .addr (sram_r_addr), .dq (sram_r_dq), .cs_n (sram_r_cs_n), .we_n (sram_r_we_n),
        .oe_n (sram_r_oe_n), .ub_n (sram_r_ub_n), .lb_n (sram_r_lb_n)
    );

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    // galois lfsr with taps 16 14 13 11
    // stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[14:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return r;
    endfunction

    // row-major placement
    function automatic int lin_addr(input entry_t e);
        return e.y * `FB_WIDTH + e.x;
    endfunction

    function automatic logic [15:0] buffer_word(input int b, input int a);
        return b ? u_sram_r.peek(a) : u_sram_l.peek(a);
    endfunction

    task automatic store_word(input int b, input int a, input logic [15:0] w);
        if (b) begin
            u_sram_r.preload(a, w);
        end else begin
            u_sram_l.preload(a, w);
        end
    endtask

    function automatic logic back_we_n();
        return back ? sram_r_we_n : sram_l_we_n;
    endfunction

    task automatic check_word(input string what, input logic [15:0] exp,
                              input logic [15:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s %s: expected %h, got %h", names[cur_test], what, exp, got);
            test_err[cur_test]++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("test %s: %s", names[cur_test], msg);
        test_err[cur_test]++;
    endtask

    // rgb565 split of the expected word
    task automatic check_fields(input logic [15:0] exp);
        check_word("red", {11'h0, exp[15:11]}, {11'h0, read_data.rgb.red});
        check_word("green", {10'h0, exp[10:5]}, {10'h0, read_data.rgb.green});
        check_word("blue", {11'h0, exp[4:0]}, {11'h0, read_data.rgb.blue});
    endtask

    task automatic add_entry(input int tst, input logic [1:0] op, input int x, input int y);
        tbl[n_built]      = '0;
        tbl[n_built].tst  = 3'(tst);
        tbl[n_built].op   = op;
        tbl[n_built].x    = 8'(x);
        tbl[n_built].y    = 7'(y);
        tbl[n_built].pix  = rand_bits(16);
        n_built++;
    endtask

    // ------------------------------------------------------------------------
    // table construction
    // ------------------------------------------------------------------------
    task automatic build_table();
        n_built = 0;
        // x stays off the probe column
        for (int i = 0; i < 6; i++) begin
            add_entry(2, OP_WRITE, rand_bits(8) % PROBE_X, rand_bits(7) % `FB_HEIGHT);
        end
        for (int i = 0; i < 8; i++) begin
            add_entry(3, OP_READ, rand_bits(8) % PROBE_X, rand_bits(7) % `FB_HEIGHT);
        end
        add_entry(4, OP_SWAP, 0, 0);
        // read back what test 2 rendered into B
        for (int i = 0; i < 4; i++) begin
            add_entry(4, OP_READ, tbl[i].x, tbl[i].y);
        end
        for (int i = 0; i < 3; i++) begin
            add_entry(4, OP_WRITE, rand_bits(8) % PROBE_X, rand_bits(7) % `FB_HEIGHT);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry(5, OP_READ, tbl[6 + i].x, tbl[6 + i].y);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry(6, OP_WRSCAN, rand_bits(8) % PROBE_X, rand_bits(7) % `FB_HEIGHT);
        end
    endtask

    // preload both chips, then replay the buffer rules for expected words
    task automatic prepare_buffers();
        int          a;
        int          front;
        logic [15:0] w;
        for (int i = 0; i <= NUM_ENTRY; i++) begin
            a = (i == NUM_ENTRY) ? PROBE_ADDR : lin_addr(tbl[i]);
            for (int b = 0; b < 2; b++) begin
                w = rand_bits(16);
                // probe word differs between the buffers
                if (i == NUM_ENTRY && b == 1) begin
                    w = ~shadow[0][a];
                end
                shadow[b][a] = w;
                store_word(b, a, w);
            end
        end
        front = 0;
        for (int i = 0; i < NUM_ENTRY; i++) begin
            a = lin_addr(tbl[i]);
            case (tbl[i].op)
                OP_SWAP: begin
                    front      = 1 - front;
                    tbl[i].exp = shadow[front][PROBE_ADDR];
                end
                OP_READ: begin
                    tbl[i].exp = shadow[front][a];
                end
                default: begin
                    // a pixel lands in the back buffer only
                    tbl[i].exp          = tbl[i].pix;
                    tbl[i].keep         = shadow[front][a];
                    shadow[1 - front][a] = tbl[i].pix;
                end
            endcase
        end
    endtask

    // ------------------------------------------------------------------------
    // operations
    // ------------------------------------------------------------------------
    task automatic write_pixel(input entry_t e);
        logic seen_low;
        int   t;
        @(negedge clk_write);
        write_x        = e.x;
        write_y        = e.y;
        write_data.raw = e.pix;
        write_enable   = 1'b1;
        @(negedge clk_write);
        write_enable = 1'b0;
        seen_low     = 1'b0;
        // one strobe pulse on the back chip
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge clk_write);
            if (back_we_n() == 1'b0) begin
                seen_low = 1'b1;
            end else if (seen_low) begin
                break;
            end
        end
        checks++;
        assert (t < TIMEOUT) else report_problem("no write strobe seen on the back chip");
    endtask

    task automatic verify_write(input entry_t e);
        check_word("back word", e.pix, buffer_word(back, lin_addr(e)));
        check_word("front word", e.keep, buffer_word(1 - back, lin_addr(e)));
    endtask

    // continuous reads of one front pixel while a write runs
    task automatic scan_front(input entry_t e);
        for (int c = 0; c < 8; c++) begin
            @(negedge clk_read);
            if (c >= 2) begin
                check_word("front read", e.keep, read_data.raw);
            end
            read_x = e.x;
            read_y = e.y;
        end
    endtask

    // pixel shows two edges after its coordinates
    task automatic stream_reads(input int first, input int n);
        entry_t e;
        for (int c = 0; c < n + 2; c++) begin
            @(negedge clk_read);
            if (c >= 2) begin
                e = tbl[first + c - 2];
                check_word("read", e.exp, read_data.raw);
                if (cur_test == 5) begin
                    check_fields(e.exp);
                end
            end
            if (c < n) begin
                read_x = tbl[first + c].x;
                read_y = tbl[first + c].y;
            end
        end
    endtask

    task automatic swap_buffers(input logic [15:0] exp);
        int t;
        @(negedge clk_write);
        swap = 1'b1;
        @(negedge clk_write);
        swap = 1'b0;
        back = 1 - back;
        // scan the probe until the new front answers
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge clk_read);
            read_x = PROBE_X;
            read_y = PROBE_Y;
            if (read_data.raw === exp) begin
                break;
            end
        end
        checks++;
        assert (t < TIMEOUT) else report_problem("front buffer did not change after swap");
    endtask

    task automatic finish_test(input int t);
        $display("test %0d %s: %0d error(s)", t, names[t], test_err[t]);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int i;
        int j;
        int total;
        rst          = 1'b1;
        swap         = 1'b0;
        write_enable = 1'b0;
        write_x      = '0;
        write_y      = '0;
        write_data   = '0;
        read_x       = '0;
        read_y       = '0;
        lfsr_state   = SEED;
        checks       = 0;
        back         = 1;
        names[1] = "reset";
        names[2] = "write placement";
        names[3] = "front reads";
        names[4] = "swap";
        names[5] = "rgb565 view";
        names[6] = "write during reads";
        for (int t = 1; t <= 6; t++) begin
            test_err[t] = 0;
        end
        build_table();

        // reset idle state
        cur_test = 1;
        @(negedge clk_read);
        prepare_buffers();
        repeat (2) @(negedge clk_read);
        check_word("strobes", 16'h003F, {10'h0, sram_l_cs_n, sram_l_we_n, sram_l_oe_n,
                                         sram_r_cs_n, sram_r_we_n, sram_r_oe_n});
        checks++;
        assert (sram_l_dq === 16'hzzzz && sram_r_dq === 16'hzzzz) else
            report_problem("dq pins driven during reset");
        check_word("read_data", 16'h0000, read_data.raw);
        @(negedge clk_read);
        rst = 1'b0;
        @(negedge clk_read);
        // write path idle after release with A as front
        check_word("write strobes", 16'h0007, {13'h0, sram_l_we_n, sram_r_we_n, sram_r_cs_n});
        // both byte lanes enabled on each chip
        check_word("byte lanes", 16'h0000, {12'h0, sram_l_ub_n, sram_l_lb_n,
                                            sram_r_ub_n, sram_r_lb_n});
        finish_test(1);

        i = 0;
        while (i < NUM_ENTRY) begin
            cur_test = tbl[i].tst;
            if (tbl[i].op == OP_READ) begin
                j = i;
                while (j < NUM_ENTRY && tbl[j].op == OP_READ && tbl[j].tst == cur_test) begin
                    j++;
                end
                stream_reads(i, j - i);
                i = j;
            end else begin
                case (tbl[i].op)
                    OP_SWAP: begin
                        swap_buffers(tbl[i].exp);
                    end
                    OP_WRSCAN: begin
                        fork
                            write_pixel(tbl[i]);
                            scan_front(tbl[i]);
                        join
                        verify_write(tbl[i]);
                    end
                    default: begin
                        write_pixel(tbl[i]);
                        verify_write(tbl[i]);
                    end
                endcase
                i++;
            end
            if (i == NUM_ENTRY || tbl[i].tst != cur_test) begin
                finish_test(cur_test);
            end
        end

        total = 0;
        for (int t = 1; t <= 6; t++) begin
            total += test_err[t];
        end
        $display("summary: 6 tests, %0d checks, %0d errors", checks, total);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
rtl/fb_pkg.sv
rtl/sram_bus_if.sv
rtl/fb_request_router.sv
rtl/sram_chip_port.sv
rtl/fb_read_select.sv
rtl/double_framebuffer.sv
testbench/sram_model.sv
testbench/tb_double_framebuffer.sv
